// File: hdc_encoder.f
rtl/hdc_pkg.sv
rtl/hv_lfsr.sv
rtl/hdc_core.sv
rtl/hdc_init_ctrl.sv
rtl/hdc_readout.sv
rtl/hdc_encoder.sv
tb/hdc_checker.sv
tb/hdc_encoder_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module hdc_encoder_tb \
    -f hdc_encoder.f -o hdc_encoder_sim

out=$(./obj_dir/hdc_encoder_sim)
echo "$out"

if echo "$out" | grep -qx "test passed"; then
    exit 0
else
    exit 1
fi

// File: tb/hdc_encoder_tb.sv
`timescale 1ns/1ps

module hdc_encoder_tb;

    localparam int MAX_SYMS  = 8;
    localparam int MAX_GAP   = 2;
    localparam int N_RANDOM  = 40;
    // four length-1 windows, rotation, wrap, random ones, restart
    localparam int N_WINDOWS = 4 + 1 + 1 + N_RANDOM + 1;
    localparam int WIN_CYCLES = MAX_SYMS * (MAX_GAP + 1) + hdc_pkg::N_CORES + 6;
    localparam int TIMEOUT_CYCLES =
        2 * (4 + 8 + hdc_pkg::ITEM_COUNT + 4 + N_WINDOWS * WIN_CYCLES);

    logic              clk;
    logic              arst_n;
    logic              init_start;
    logic              sym_valid;
    hdc_pkg::sym_t     sym;
    logic              win_start;
    hdc_pkg::pos_t     window_len;
    logic              update;
    logic              init_busy;
    logic              out_valid;
    hdc_pkg::hv_word_t out_word;
    int                chk_errors;
    int                tb_errors;
    int                cycle_count;
    integer            seed;

    // model copy of every core's item memory
    hdc_pkg::hv_word_t item_ref [hdc_pkg::N_CORES][hdc_pkg::ITEM_COUNT];
    // symbols of the window under test
    hdc_pkg::sym_t     win_syms [MAX_SYMS];
    int                win_n;

    hdc_encoder dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .init_start (init_start),
        .sym_valid  (sym_valid),
        .sym        (sym),
        .win_start  (win_start),
        .window_len (window_len),
        .update     (update),
        .init_busy  (init_busy),
        .out_valid  (out_valid),
        .out_word   (out_word)
    );

    hdc_checker u_checker (
        .clk         (clk),
        .arst_n      (arst_n),
        .out_valid   (out_valid),
        .out_word    (out_word),
        .error_count (chk_errors)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, readout or init never finished", cycle_count);
            $display("test failed");
            $finish;
        end
    end

    function automatic hdc_pkg::hv_word_t lfsr_model_step(input hdc_pkg::hv_word_t s);
        hdc_pkg::hv_word_t n;
        n = {1'b0, s[hdc_pkg::WORD_W-1:1]};
        if (s[0]) begin
            n = n ^ hdc_pkg::LFSR_TAPS;
        end
        return n;
    endfunction

    function automatic hdc_pkg::hv_word_t rotate_right(input hdc_pkg::hv_word_t w, input int amt);
        hdc_pkg::hv_word_t r;
        r = w;
        for (int i = 0; i < amt; i++) begin
            r = {r[0], r[hdc_pkg::WORD_W-1:1]};
        end
        return r;
    endfunction

    // expected accumulator of one core after the current window
    function automatic hdc_pkg::hv_word_t window_model(input int core, input int len);
        hdc_pkg::hv_word_t acc;
        int                pos;
        acc = '0;
        pos = 0;
        for (int j = 0; j < win_n; j++) begin
            if (j == 0) begin
                acc = item_ref[core][win_syms[j]];
                pos = (len == 1) ? 0 : 1;
            end else begin
                acc = acc ^ rotate_right(item_ref[core][win_syms[j]], pos);
                pos = (pos == len - 1) ? 0 : pos + 1;
            end
        end
        return acc;
    endfunction

    task automatic build_item_ref();
        hdc_pkg::hv_word_t s;
        for (int k = 0; k < hdc_pkg::N_CORES; k++) begin
            s = hdc_pkg::LFSR_SEED_BASE + hdc_pkg::hv_word_t'(k) * hdc_pkg::LFSR_SEED_STEP;
            for (int i = 0; i < hdc_pkg::ITEM_COUNT; i++) begin
                item_ref[k][i] = s;
                s = lfsr_model_step(s);
            end
        end
    endtask

    task automatic send_symbol(input hdc_pkg::sym_t s, input logic first);
        @(negedge clk);
        sym_valid = 1'b1;
        sym       = s;
        win_start = first;
    endtask

    task automatic hold_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            sym_valid = 1'b0;
            win_start = 1'b0;
        end
    endtask

    task automatic queue_burst(input string name, input int len, input int n_words);
        for (int k = 0; k < n_words; k++) begin
            u_checker.push_expect($sformatf("%s core%0d", name, k), window_model(k, len));
        end
    endtask

    task automatic wait_drain();
        @(negedge clk);
        while (u_checker.pending_count() != 0 || out_valid) begin
            @(negedge clk);
        end
    endtask

    // feed win_syms as one window, then pulse update and wait for the words
    task automatic feed_window(input string name, input int len, input int gap_max);
        window_len = hdc_pkg::pos_t'(len);
        for (int j = 0; j < win_n; j++) begin
            send_symbol(win_syms[j], j == 0);
            if (gap_max > 0 && j < win_n - 1) begin
                hold_idle(int'($unsigned($random(seed)) % (gap_max + 1)));
            end
        end
        hold_idle(1);
        @(negedge clk);
        update = 1'b1;
        queue_burst(name, len, hdc_pkg::N_CORES);
        @(negedge clk);
        update = 1'b0;
        wait_drain();
    endtask

    task automatic init_sequence();
        int busy_cycles;
        repeat (5) begin
            @(negedge clk);
            if (init_busy !== 1'b0 || out_valid !== 1'b0) begin
                $display("init_busy or out_valid high before init was started");
                tb_errors++;
            end
        end
        init_start = 1'b1;
        @(negedge clk);
        init_start  = 1'b0;
        busy_cycles = 0;
        while (init_busy === 1'b1 && busy_cycles < 2 * hdc_pkg::ITEM_COUNT) begin
            busy_cycles++;
            // a start request mid-fill must be ignored
            init_start = (busy_cycles == 10);
            @(negedge clk);
        end
        init_start = 1'b0;
        if (busy_cycles != hdc_pkg::ITEM_COUNT) begin
            $display("[FAIL] init_busy_cycles expected %0d actual %0d",
                     hdc_pkg::ITEM_COUNT, busy_cycles);
            tb_errors++;
        end
        hold_idle(3);
        if (init_busy !== 1'b0) begin
            $display("init_busy came back after the fill finished");
            tb_errors++;
        end
    endtask

    // second update lands two cycles into the first readout
    task automatic restart_readout();
        win_n       = 3;
        win_syms[0] = 7'd10;
        win_syms[1] = 7'd20;
        win_syms[2] = 7'd30;
        window_len  = hdc_pkg::pos_t'(3);
        for (int j = 0; j < win_n; j++) begin
            send_symbol(win_syms[j], j == 0);
        end
        hold_idle(1);
        @(negedge clk);
        update = 1'b1;
        queue_burst("restart_first", 3, 2);
        @(negedge clk);
        update = 1'b0;
        @(negedge clk);
        update = 1'b1;
        queue_burst("restart_second", 3, hdc_pkg::N_CORES);
        @(negedge clk);
        update = 1'b0;
        wait_drain();
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        init_start  = 1'b0;
        sym_valid   = 1'b0;
        sym         = '0;
        win_start   = 1'b0;
        window_len  = hdc_pkg::pos_t'(1);
        update      = 1'b0;
        tb_errors   = 0;
        cycle_count = 0;
        seed        = 83;
        win_n       = 0;
        build_item_ref();
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        init_sequence();

        foreach (win_syms[i]) win_syms[i] = '0;
        win_n = 1;
        for (int i = 0; i < 4; i++) begin
            win_syms[0] = (i == 0) ? 7'd0 : (i == 1) ? 7'd1 : (i == 2) ? 7'd57 : 7'd99;
            feed_window($sformatf("item_sym%0d", win_syms[0]), 1, 0);
        end

        win_n = 3;
        for (int j = 0; j < 3; j++) begin
            win_syms[j] = hdc_pkg::sym_t'(j);
        end
        feed_window("rotate_xor", 3, 0);

        // positions 0 1 0 1 0
        win_n = 5;
        for (int j = 0; j < 5; j++) begin
            win_syms[j] = hdc_pkg::sym_t'(5 + 19 * j);
        end
        feed_window("pos_wrap", 2, 0);

        for (int w = 0; w < N_RANDOM; w++) begin
            int len;
            len   = 1 + int'($unsigned($random(seed)) % MAX_SYMS);
            win_n = 1 + int'($unsigned($random(seed)) % MAX_SYMS);
            for (int j = 0; j < win_n; j++) begin
                win_syms[j] = hdc_pkg::sym_t'($unsigned($random(seed)) % hdc_pkg::ITEM_COUNT);
            end
            feed_window($sformatf("random_win%0d", w), len, MAX_GAP);
        end

        restart_readout();

        hold_idle(8);
        $display("errors: %0d total, %0d in control checks, %0d in readout checks",
                 tb_errors + chk_errors, tb_errors, chk_errors);
        if (tb_errors + chk_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: tb/hdc_checker.sv
`timescale 1ns/1ps

module hdc_checker (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              out_valid,
    input  hdc_pkg::hv_word_t out_word,
    output int                error_count
);

    // quiet cycles allowed before a pending word counts as lost
    localparam int IDLE_LIMIT = hdc_pkg::N_CORES + 4;

    hdc_pkg::hv_word_t exp_q [$];
    string             name_q [$];
    int                errors = 0;
    int                quiet_cycles = 0;

    task automatic push_expect(input string name, input hdc_pkg::hv_word_t word);
        name_q.push_back(name);
        exp_q.push_back(word);
    endtask

    function automatic int pending_count();
        return exp_q.size();
    endfunction

    // outputs are registered, so they are settled by the falling edge
    always @(negedge clk) begin : compare_proc
        hdc_pkg::hv_word_t exp_word;
        string             name;
        if (arst_n) begin
            if (out_valid) begin
                quiet_cycles = 0;
                if (exp_q.size() == 0) begin
                    $display("out_valid went high with no word expected, out_word=%08h",
                             out_word);
                    errors++;
                end else begin
                    exp_word = exp_q.pop_front();
                    name     = name_q.pop_front();
                    if (out_word !== exp_word) begin
                        $display("[FAIL] %s expected %08h actual %08h",
                                 name, exp_word, out_word);
                        errors++;
                    end
                end
            end else if (exp_q.size() != 0) begin
                quiet_cycles++;
                if (quiet_cycles > IDLE_LIMIT) begin
                    // drop the whole stalled burst
                    while (exp_q.size() != 0) begin
                        $display("readout word for %s never appeared", name_q.pop_front());
                        void'(exp_q.pop_front());
                        errors++;
                    end
                    quiet_cycles = 0;
                end
            end else begin
                quiet_cycles = 0;
            end
        end
    end

    assign error_count = errors;

endmodule

// File: rtl/hdc_encoder.sv
`timescale 1ns/1ps

module hdc_encoder (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              init_start,
    input  logic              sym_valid,
    input  hdc_pkg::sym_t     sym,
    input  logic              win_start,
    input  hdc_pkg::pos_t     window_len,
    input  logic              update,
    output logic              init_busy,
    output logic              out_valid,
    output hdc_pkg::hv_word_t out_word
);

    logic          mem_we;
    hdc_pkg::sym_t mem_addr;
    logic          lfsr_step;

    hdc_pkg::hv_word_t                          lfsr_value [hdc_pkg::N_CORES];
    logic [hdc_pkg::N_CORES*hdc_pkg::WORD_W-1:0] acc_all;

    hdc_init_ctrl u_init_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .init_start (init_start),
        .init_busy  (init_busy),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .lfsr_step  (lfsr_step)
    );

    for (genvar k = 0; k < hdc_pkg::N_CORES; k++) begin : g_core
        // each core gets its own seed so slices differ
        hv_lfsr #(
            .SEED (hdc_pkg::hv_word_t'(hdc_pkg::LFSR_SEED_BASE +
                   hdc_pkg::hv_word_t'(k) * hdc_pkg::LFSR_SEED_STEP))
        ) u_lfsr (
            .clk    (clk),
            .arst_n (arst_n),
            .step   (lfsr_step),
            .value  (lfsr_value[k])
        );

        hdc_core u_core (
            .clk        (clk),
            .arst_n     (arst_n),
            .mem_we     (mem_we),
            .mem_addr   (mem_addr),
            .wr_data    (lfsr_value[k]),
            .sym_valid  (sym_valid),
            .sym        (sym),
            .win_start  (win_start),
            .window_len (window_len),
            .acc        (acc_all[k*hdc_pkg::WORD_W +: hdc_pkg::WORD_W])
        );
    end

    hdc_readout u_readout (
        .clk       (clk),
        .arst_n    (arst_n),
        .update    (update),
        .acc_all   (acc_all),
        .out_valid (out_valid),
        .out_word  (out_word)
    );

endmodule

// File: rtl/hdc_readout.sv
`timescale 1ns/1ps

module hdc_readout (
    input  logic                                           clk,
    input  logic                                           arst_n,
    input  logic                                           update,
    input  logic [hdc_pkg::N_CORES*hdc_pkg::WORD_W-1:0]    acc_all,
    output logic                                           out_valid,
    output hdc_pkg::hv_word_t                              out_word
);

    // words of cores 1 .. N_CORES-1 wait here while core 0 comes straight from acc_all
    hdc_pkg::hv_word_t chain [hdc_pkg::N_CORES-1];

    logic [hdc_pkg::READ_CNT_W-1:0] remaining;
    logic                           first_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            remaining <= '0;
            first_q   <= 1'b0;
        end else if (update) begin
            // restart from core 0 even mid-sequence
            remaining <= hdc_pkg::READ_CNT_W'(hdc_pkg::N_CORES);
            first_q   <= 1'b1;
        end else begin
            first_q <= 1'b0;
            if (remaining != '0) begin
                remaining <= remaining - 1'b1;
            end
        end
    end

    // accumulators still hold their post-update value during first cycle
    always_ff @(posedge clk) begin
        if (first_q) begin
            for (int i = 0; i < hdc_pkg::N_CORES - 1; i++) begin
                chain[i] <= acc_all[(i+1)*hdc_pkg::WORD_W +: hdc_pkg::WORD_W];
            end
        end else begin
            for (int i = 0; i < hdc_pkg::N_CORES - 2; i++) begin
                chain[i] <= chain[i+1];
            end
        end
    end

    assign out_valid = (remaining != '0);
    assign out_word  = first_q ? acc_all[hdc_pkg::WORD_W-1:0] : chain[0];

endmodule

// File: rtl/hdc_init_ctrl.sv
`timescale 1ns/1ps

module hdc_init_ctrl (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          init_start,
    output logic          init_busy,
    output logic          mem_we,
    output hdc_pkg::sym_t mem_addr,
    output logic          lfsr_step
);

    localparam hdc_pkg::sym_t ADDR_LAST = hdc_pkg::sym_t'(hdc_pkg::ITEM_COUNT - 1);

    hdc_pkg::init_state_t state;
    hdc_pkg::sym_t        addr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= hdc_pkg::IDLE;
            addr  <= '0;
        end else begin
            case (state)
                hdc_pkg::IDLE: begin
                    // start requests during FILL never reach here
                    if (init_start) begin
                        state <= hdc_pkg::FILL;
                        addr  <= '0;
                    end
                end
                hdc_pkg::FILL: begin
                    if (addr == ADDR_LAST) begin
                        state <= hdc_pkg::IDLE;
                        addr  <= '0;
                    end else begin
                        addr <= addr + 1'b1;
                    end
                end
                default: state <= hdc_pkg::IDLE;
            endcase
        end
    end

    // one write and one lfsr step per FILL cycle
    assign init_busy = (state == hdc_pkg::FILL);
    assign mem_we    = init_busy;
    assign lfsr_step = init_busy;
    assign mem_addr  = addr;

    a_addr_in_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        mem_we |-> (mem_addr < hdc_pkg::ITEM_COUNT)
    );

endmodule

// File: rtl/hdc_core.sv
`timescale 1ns/1ps

module hdc_core (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              mem_we,
    input  hdc_pkg::sym_t     mem_addr,
    input  hdc_pkg::hv_word_t wr_data,
    input  logic              sym_valid,
    input  hdc_pkg::sym_t     sym,
    input  logic              win_start,
    input  hdc_pkg::pos_t     window_len,
    output hdc_pkg::hv_word_t acc
);

    // one pseudo-random word per symbol
    hdc_pkg::hv_word_t item_mem [hdc_pkg::ITEM_COUNT];

    // stage 1: looked-up item and its qualifiers
    hdc_pkg::hv_word_t item_q;
    logic              valid_q;
    logic              start_q;

    // stage 2: window position and running accumulator
    hdc_pkg::pos_t     pos;
    hdc_pkg::hv_word_t acc_q;

    function automatic hdc_pkg::hv_word_t rotr(
        input hdc_pkg::hv_word_t word,
        input hdc_pkg::pos_t     amt
    );
        hdc_pkg::hv_word_t rot;
        // a shift by the full width gives zero, so amt == 0 is safe
        rot = (word >> amt) | (word << (hdc_pkg::WORD_W - int'(amt)));
        return rot;
    endfunction

    // item memory write port and registered read
    always_ff @(posedge clk) begin
        if (mem_we) begin
            item_mem[mem_addr] <= wr_data;
        end
        if (sym_valid) begin
            item_q <= item_mem[sym];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
            start_q <= 1'b0;
        end else begin
            valid_q <= sym_valid;
            start_q <= sym_valid & win_start;
        end
    end

    // fold one item per valid cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pos   <= '0;
            acc_q <= '0;
        end else if (valid_q) begin
            if (start_q) begin
                // first item of a window goes in unrotated
                acc_q <= item_q;
                if (window_len == hdc_pkg::pos_t'(1)) begin
                    pos <= '0;
                end else begin
                    pos <= hdc_pkg::pos_t'(1);
                end
            end else begin
                acc_q <= acc_q ^ rotr(item_q, pos);
                if (pos == hdc_pkg::pos_t'(window_len - 1'b1)) begin
                    pos <= '0;
                end else begin
                    pos <= pos + 1'b1;
                end
            end
        end
    end

    assign acc = acc_q;

    // symbols past the memory depth would read garbage
    a_sym_in_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        sym_valid |-> (sym < hdc_pkg::ITEM_COUNT)
    );

    // encoding while the init sequencer still fills the memory
    a_no_read_during_fill: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(mem_we && sym_valid)
    );

endmodule

// File: rtl/hv_lfsr.sv
`timescale 1ns/1ps

module hv_lfsr #(
    parameter hdc_pkg::hv_word_t SEED = hdc_pkg::LFSR_SEED_BASE
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              step,
    output hdc_pkg::hv_word_t value
);

    hdc_pkg::hv_word_t state;

    // right-shifting galois form, taps folded in when lsb falls out
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= SEED;
        end else if (step) begin
            if (state[0]) begin
                state <= (state >> 1) ^ hdc_pkg::LFSR_TAPS;
            end else begin
                state <= state >> 1;
            end
        end
    end

    assign value = state;

    // all-zero state would lock up and fill the item memory with zeros
    a_state_nonzero: assert property (
        @(posedge clk) disable iff (!arst_n)
        state != '0
    );

endmodule

// File: rtl/hdc_pkg.sv
package hdc_pkg;

    // encoder geometry
    localparam int N_CORES    = 4;
    localparam int ITEM_COUNT = 100;
    localparam int WORD_W     = 32;
    localparam int SYM_W      = 7;
    localparam int POS_W      = 5;

    // readout counter has to hold N_CORES itself
    localparam int READ_CNT_W = $clog2(N_CORES + 1);

    // galois feedback mask, applied when the bit shifted out is 1
    localparam logic [WORD_W-1:0] LFSR_TAPS = 32'h80200003;

    // core k is seeded with LFSR_SEED_BASE + k * LFSR_SEED_STEP
    localparam logic [WORD_W-1:0] LFSR_SEED_BASE = 32'h1ace_b00c;
    localparam logic [WORD_W-1:0] LFSR_SEED_STEP = 32'h0f35_2e17;

    // one slice of the hypervector, owned by one core
    typedef logic [WORD_W-1:0] hv_word_t;

    // symbol value, doubles as item memory address
    typedef logic [SYM_W-1:0] sym_t;

    // rotation amount inside a window, and the window length
    typedef logic [POS_W-1:0] pos_t;

    // init sequencer states
    typedef enum logic {
        IDLE,
        FILL
    } init_state_t;

endpackage
